// ==== mic_loopback_config.svh ====
`ifndef MIC_LOOPBACK_CONFIG_SVH
`define MIC_LOOPBACK_CONFIG_SVH

// clk cycles per half period of sck and bclk
`define SCK_DIV      2

// bit clocks per word select half
`define SLOT_BITS    32

// significant bits of one microphone sample
`define MIC_BITS     24

// bits played per dac slot
`define OUT_BITS     16

`define FIFO_DEPTH   8
`define LED_COUNT    6

// mirror the led bar as on the lab board, set to 0 for natural order
`define REVERSE_LED  1

`endif

// ==== mic_loopback_pkg.sv ====
`include "mic_loopback_config.svh"

package mic_loopback_pkg;

    // ----------------------------------------
    // sample path types

    // one microphone sample, tagged with the slot it came from
    typedef struct packed
    {
        logic signed [`MIC_BITS - 1:0] pcm;
        logic                          right;
    } audio_sample_t;

    // word sent to the dac and to the level meter
    typedef logic signed [`OUT_BITS - 1:0] play_word_t;

    // ----------------------------------------

    // keep the top bits of pcm, the rest is below the dac resolution
    function automatic play_word_t sample_to_play
    (
        input audio_sample_t sample
    );
        return sample.pcm[`MIC_BITS - 1 -: `OUT_BITS];
    endfunction

endpackage

// ==== mic_i2s_receiver.sv ====
`timescale 1ns/10ps
`include "mic_loopback_config.svh"

module mic_i2s_receiver
(
    input  logic                            clk,
    input  logic                            i_rst,
    input  logic                            i_lr,
    input  logic                            i_sd,
    output logic                            o_sck,
    output logic                            o_ws,
    output mic_loopback_pkg::audio_sample_t o_sample,
    output logic                            o_sample_stb
);

    import mic_loopback_pkg::*;

    localparam int DIV_W = $clog2(`SCK_DIV + 1);
    localparam int BIT_W = $clog2(`SLOT_BITS);

    logic [DIV_W - 1:0]     div_cnt;
    logic                   sck_tick;
    logic                   sck_rise;
    logic                   sck_fall;
    logic [BIT_W - 1:0]     bit_cnt;
    logic                   capture;
    logic                   last_bit;
    logic [`MIC_BITS - 1:0] shift_q;
    logic [`MIC_BITS - 1:0] shift_next;
    audio_sample_t          sample_q;

    // ----------------------------------------
    // sck and ws generation

    assign sck_tick = (div_cnt == DIV_W'(`SCK_DIV - 1));
    assign sck_rise = sck_tick & ~o_sck;
    assign sck_fall = sck_tick & o_sck;

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            div_cnt <= '0;
            o_sck   <= 1'b0;
        end
        else if (sck_tick)
        begin
            div_cnt <= '0;
            o_sck   <= ~o_sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // ws flips on the falling edge that ends a slot
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            bit_cnt <= '0;
            o_ws    <= 1'b0;
        end
        else if (sck_fall)
        begin
            if (bit_cnt == BIT_W'(`SLOT_BITS - 1))
            begin
                bit_cnt <= '0;
                o_ws    <= ~o_ws;
            end
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // capture, bit 0 of the slot is the i2s delay bit

    assign capture    = sck_rise && (o_ws == i_lr) && (bit_cnt != '0)
                        && (bit_cnt <= BIT_W'(`MIC_BITS));
    assign last_bit   = capture && (bit_cnt == BIT_W'(`MIC_BITS));
    assign shift_next = {shift_q[`MIC_BITS - 2:0], i_sd};

    always_ff @(posedge clk)
    begin
        if (capture)
            shift_q <= shift_next;
        if (last_bit)
        begin
            sample_q.pcm   <= shift_next;
            sample_q.right <= o_ws;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_sample_stb <= 1'b0;
        else
            o_sample_stb <= last_bit;
    end

    assign o_sample = sample_q;

    // one strobe per slot, never back to back
    a_stb_single : assert property (@(posedge clk) disable iff (i_rst)
        o_sample_stb |=> !o_sample_stb);

endmodule

// ==== sample_fifo.sv ====
`timescale 1ns/10ps
`include "mic_loopback_config.svh"

module sample_fifo
#(
    parameter int DEPTH = `FIFO_DEPTH
)
(
    input  logic                            clk,
    input  logic                            i_rst,
    input  logic                            i_wr_stb,
    input  mic_loopback_pkg::audio_sample_t i_wr_data,
    input  logic                            i_pop,
    output mic_loopback_pkg::audio_sample_t o_head,
    output logic                            o_empty,
    output logic                            o_overflow
);

    import mic_loopback_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    audio_sample_t      mem [DEPTH];
    logic [PTR_W - 1:0] wr_ptr;
    logic [PTR_W - 1:0] rd_ptr;
    logic [CNT_W - 1:0] count;
    logic               full;
    logic               wr_en;

    assign full    = (count == CNT_W'(DEPTH));
    assign wr_en   = i_wr_stb & ~full;
    assign o_empty = (count == '0);
    assign o_head  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= i_wr_data;
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (i_pop)
                rd_ptr <= rd_ptr + 1'b1;

            case ({wr_en, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // sticky until reset
            if (i_wr_stb && full)
                o_overflow <= 1'b1;
        end
    end

    a_no_pop_empty : assert property (@(posedge clk) disable iff (i_rst)
        !(i_pop && o_empty));

endmodule

// ==== i2s_audio_out.sv ====
`timescale 1ns/10ps
`include "mic_loopback_config.svh"

module i2s_audio_out
(
    input  logic                            clk,
    input  logic                            i_rst,
    input  logic                            i_mute,
    input  mic_loopback_pkg::audio_sample_t i_head,
    input  logic                            i_empty,
    output logic                            o_pop,
    output logic                            o_mclk,
    output logic                            o_bclk,
    output logic                            o_lrclk,
    output logic                            o_sdata,
    output mic_loopback_pkg::play_word_t    o_play,
    output logic                            o_play_stb
);

    import mic_loopback_pkg::*;

    localparam int DIV_W = $clog2(`SCK_DIV + 1);
    localparam int BIT_W = $clog2(`SLOT_BITS);

    logic [DIV_W - 1:0] div_cnt;
    logic               bclk_tick;
    logic               bclk_fall;
    logic [BIT_W - 1:0] bit_cnt;
    logic               slot_start;
    play_word_t         next_word;
    play_word_t         word_q;
    play_word_t         play_q;

    // ----------------------------------------
    // dac clocks

    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_mclk <= 1'b0;
        else
            o_mclk <= ~o_mclk;
    end

    assign bclk_tick = (div_cnt == DIV_W'(`SCK_DIV - 1));
    assign bclk_fall = bclk_tick & o_bclk;

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            div_cnt <= '0;
            o_bclk  <= 1'b0;
        end
        else if (bclk_tick)
        begin
            div_cnt <= '0;
            o_bclk  <= ~o_bclk;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign slot_start = bclk_fall && (bit_cnt == BIT_W'(`SLOT_BITS - 1));

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            bit_cnt <= '0;
            o_lrclk <= 1'b0;
        end
        else if (slot_start)
        begin
            bit_cnt <= '0;
            o_lrclk <= ~o_lrclk;
        end
        else if (bclk_fall)
            bit_cnt <= bit_cnt + 1'b1;
    end

    // ----------------------------------------
    // word select, the new slot is the inverse of the current lrclk

    assign o_pop     = slot_start && !i_empty && !i_mute && (i_head.right == ~o_lrclk);
    assign next_word = o_pop ? sample_to_play(i_head) : '0;

    // msb leaves one bclk after the slot edge, zeros fill the tail
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            word_q  <= '0;
            o_sdata <= 1'b0;
        end
        else if (slot_start)
        begin
            word_q  <= next_word;
            o_sdata <= 1'b0;
        end
        else if (bclk_fall)
        begin
            o_sdata <= word_q[`OUT_BITS - 1];
            word_q  <= word_q << 1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (o_pop)
            play_q <= next_word;
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_play_stb <= 1'b0;
        else
            o_play_stb <= o_pop;
    end

    assign o_play = play_q;

    // a non-empty fifo always shows a written sample at its head
    a_head_known : assert property (@(posedge clk) disable iff (i_rst)
        !i_empty |-> !$isunknown(i_head));

endmodule

// ==== level_meter.sv ====
`timescale 1ns/10ps
`include "mic_loopback_config.svh"

module level_meter
(
    input  logic                         clk,
    input  logic                         i_rst,
    input  mic_loopback_pkg::play_word_t i_play,
    input  logic                         i_play_stb,
    output logic [`LED_COUNT - 1:0]      o_led
);

    import mic_loopback_pkg::*;

    // bit 14 is the top magnitude bit of a 16-bit word
    localparam int TOP_BIT = `OUT_BITS - 2;
    localparam int LOW_BIT = TOP_BIT - `LED_COUNT + 1;

    play_word_t              mag;
    logic [`LED_COUNT - 1:0] bar;
    logic [`LED_COUNT - 1:0] bar_q;

    // led i is lit when any bit at or above LOW_BIT + i is set
    always_comb
    begin
        mag = i_play[`OUT_BITS - 1] ? ~i_play : i_play;
        for (int i = 0; i < `LED_COUNT; i++)
            bar[i] = |(mag[TOP_BIT:0] >> (LOW_BIT + i));
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
            bar_q <= '0;
        else if (i_play_stb)
            bar_q <= bar;
    end

    // ----------------------------------------
    // board leds are active low

    generate
        if (`REVERSE_LED)
        begin : g_reverse
            for (genvar i = 0; i < `LED_COUNT; i++)
            begin : g_bit
                assign o_led[i] = ~bar_q[`LED_COUNT - 1 - i];
            end
        end
        else
        begin : g_direct
            assign o_led = ~bar_q;
        end
    endgenerate

endmodule

// ==== mic_loopback.sv ====
`timescale 1ns/10ps
`include "mic_loopback_config.svh"

module mic_loopback
(
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_lr,
    input  logic                    i_mute,
    input  logic                    i_mic_sd,
    output logic                    o_mic_sck,
    output logic                    o_mic_ws,
    output logic                    o_mclk,
    output logic                    o_bclk,
    output logic                    o_lrclk,
    output logic                    o_sdata,
    output logic [`LED_COUNT - 1:0] o_led,
    output logic                    o_overflow
);

    import mic_loopback_pkg::*;

    audio_sample_t sample;
    logic          sample_stb;
    audio_sample_t head;
    logic          empty;
    logic          pop;
    play_word_t    play;
    logic          play_stb;

    // ----------------------------------------
    // microphone side

    mic_i2s_receiver u_receiver
    (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_lr         (i_lr),
        .i_sd         (i_mic_sd),
        .o_sck        (o_mic_sck),
        .o_ws         (o_mic_ws),
        .o_sample     (sample),
        .o_sample_stb (sample_stb)
    );

    sample_fifo #(.DEPTH(`FIFO_DEPTH)) u_fifo
    (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_wr_stb   (sample_stb),
        .i_wr_data  (sample),
        .i_pop      (pop),
        .o_head     (head),
        .o_empty    (empty),
        .o_overflow (o_overflow)
    );

    // ----------------------------------------
    // dac side and leds

    i2s_audio_out u_audio_out
    (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_mute     (i_mute),
        .i_head     (head),
        .i_empty    (empty),
        .o_pop      (pop),
        .o_mclk     (o_mclk),
        .o_bclk     (o_bclk),
        .o_lrclk    (o_lrclk),
        .o_sdata    (o_sdata),
        .o_play     (play),
        .o_play_stb (play_stb)
    );

    level_meter u_meter
    (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_play     (play),
        .i_play_stb (play_stb),
        .o_led      (o_led)
    );

endmodule

// ==== tb_mic_loopback.sv ====
`timescale 1ns/10ps
`include "mic_loopback_config.svh"

module tb_mic_loopback;

    localparam int FRAME_CYCLES   = 2 * `SLOT_BITS * 2 * `SCK_DIV;
    // the phases below take about 34 frames
    localparam int RUN_FRAMES     = 40;
    localparam int TIMEOUT_CYCLES = RUN_FRAMES * FRAME_CYCLES + 200;
    localparam int LOOP_FRAMES    = 6;
    localparam int MUTE_FRAMES    = `FIFO_DEPTH + 3;
    localparam int DRAIN_FRAMES   = `FIFO_DEPTH + 2;

    logic                    clk;
    logic                    i_rst;
    logic                    i_lr;
    logic                    i_mute;
    logic                    i_mic_sd;
    logic                    o_mic_sck;
    logic                    o_mic_ws;
    logic                    o_mclk;
    logic                    o_bclk;
    logic                    o_lrclk;
    logic                    o_sdata;
    logic [`LED_COUNT - 1:0] o_led;
    logic                    o_overflow;

    // model of the fifo contents, oldest first
    logic [`OUT_BITS - 1:0]  ref_q [$];
    int                      played_count = 0;
    int                      cycle_count = 0;

    // decoder state
    logic                    prev_bclk;
    logic                    prev_lrclk;
    logic                    cur_slot;
    logic                    slot_muted;
    int                      bit_idx;
    logic [`OUT_BITS - 1:0]  shift;

    // next mclk level
    logic                    mclk_expect;

    mic_loopback u_mic_loopback
    (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_lr       (i_lr),
        .i_mute     (i_mute),
        .i_mic_sd   (i_mic_sd),
        .o_mic_sck  (o_mic_sck),
        .o_mic_ws   (o_mic_ws),
        .o_mclk     (o_mclk),
        .o_bclk     (o_bclk),
        .o_lrclk    (o_lrclk),
        .o_sdata    (o_sdata),
        .o_led      (o_led),
        .o_overflow (o_overflow)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    // ----------------------------------------
    // helpers

    task automatic abort_run(input string reason);
        $display("ERROR at %0t: %s", $time, reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value
    (
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
            abort_run("value check failed");
        end
    endtask

    function automatic logic [`MIC_BITS - 1:0] new_mic_word();
        logic [31:0]            rnd;
        logic [`MIC_BITS - 1:0] word;

        rnd  = $urandom;
        word = rnd[`MIC_BITS - 1:0];
        // top bits of zero would play as silence
        if (word[`MIC_BITS - 1 -: `OUT_BITS] == '0)
            word[`MIC_BITS - `OUT_BITS] = 1'b1;
        return word;
    endfunction

    // thermometer bar from the highest magnitude bit in 14 down to 9
    function automatic logic [`LED_COUNT - 1:0] led_expect(input logic [`OUT_BITS - 1:0] word);
        logic [`OUT_BITS - 1:0]  mag;
        logic [`LED_COUNT - 1:0] bar;
        logic [`LED_COUNT - 1:0] led;
        int                      lit;

        mag = word[`OUT_BITS - 1] ? ~word : word;
        lit = 0;
        for (int b = 0; b < `LED_COUNT; b++)
        begin
            if (mag[`OUT_BITS - 1 - `LED_COUNT + b])
                lit = b + 1;
        end
        bar = '0;
        for (int b = 0; b < lit; b++)
            bar[b] = 1'b1;
        led = bar;
        if (`REVERSE_LED)
        begin
            for (int b = 0; b < `LED_COUNT; b++)
                led[b] = bar[`LED_COUNT - 1 - b];
        end
        return ~led;
    endfunction

    task automatic check_slot_word(input logic [`OUT_BITS - 1:0] word);
        logic [`OUT_BITS - 1:0] expected;

        expected = '0;
        if (!slot_muted && cur_slot == i_lr && ref_q.size() > 0)
            expected = ref_q.pop_front();
        check_value("o_sdata word", expected, word);
        if (word != '0)
        begin
            check_value("o_led", led_expect(word), o_led);
            played_count++;
        end
    endtask

    task automatic apply_reset(input logic lr);
        i_rst  <= 1'b1;
        i_lr   <= lr;
        i_mute <= 1'b0;
        repeat (2) @(negedge clk);
        i_rst <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_reset_state();
        check_value("o_led", {`LED_COUNT{1'b1}}, o_led);
        check_value("o_overflow", 0, o_overflow);
        check_value("o_sdata", 0, o_sdata);
    endtask

    task automatic wait_frames(input int count);
        repeat (count) @(posedge o_lrclk);
        @(negedge clk);
    endtask

    task automatic require_played(input int minimum);
        if (played_count < minimum)
            abort_run($sformatf("only %0d samples played, at least %0d expected",
                                played_count, minimum));
    endtask

    // ----------------------------------------
    // microphone model, one bit per sck falling edge

    initial
    begin
        logic [31:0]            rnd;
        logic [`MIC_BITS - 1:0] word;
        logic                   cur_ws;
        logic                   prev_sck;
        int                     idx;

        // seed the random stream once
        rnd      = $urandom(32'h34465eee);
        i_mic_sd = 1'b0;
        forever
        begin
            @(negedge clk);
            if (i_rst)
            begin
                cur_ws   = 1'b0;
                prev_sck = 1'b0;
                idx      = 0;
                word     = new_mic_word();
                ref_q.delete();
            end
            else
            begin
                if (prev_sck && !o_mic_sck)
                begin
                    if (o_mic_ws != cur_ws)
                    begin
                        cur_ws = o_mic_ws;
                        idx    = 0;
                        word   = new_mic_word();
                    end
                    else
                        idx = idx + 1;

                    // delay bit and tail carry noise the receiver must ignore
                    rnd = $urandom;
                    if (idx >= 1 && idx <= `MIC_BITS)
                        i_mic_sd <= word[`MIC_BITS - idx];
                    else
                        i_mic_sd <= rnd[0];

                    // a full fifo drops the sample
                    if (idx == `MIC_BITS && cur_ws == i_lr)
                    begin
                        if (ref_q.size() < `FIFO_DEPTH)
                            ref_q.push_back(word[`MIC_BITS - 1 -: `OUT_BITS]);
                    end
                end
                prev_sck = o_mic_sck;
            end
        end
    end

    // ----------------------------------------
    // dac decoder

    always @(negedge clk)
    begin
        if (i_rst)
        begin
            prev_bclk  = 1'b0;
            prev_lrclk = 1'b0;
            cur_slot   = 1'b1;
            bit_idx    = 0;
            shift      = '0;
            slot_muted = i_mute;
        end
        else
        begin
            // mute as seen at the lrclk edge, where the dac decides
            if (o_lrclk != prev_lrclk)
                slot_muted = i_mute;
            if (!prev_bclk && o_bclk)
            begin
                if (o_lrclk != cur_slot)
                begin
                    cur_slot = o_lrclk;
                    bit_idx  = 0;
                    shift    = '0;
                end
                else
                    bit_idx = bit_idx + 1;

                if (bit_idx >= 1 && bit_idx <= `OUT_BITS)
                    shift = {shift[`OUT_BITS - 2:0], o_sdata};
                else
                    check_value("o_sdata pad bit", 0, o_sdata);
                if (bit_idx == `OUT_BITS)
                    check_slot_word(shift);
            end
            prev_bclk  = o_bclk;
            prev_lrclk = o_lrclk;
        end
    end

    // mclk is clk divided by two, low out of reset
    always @(negedge clk)
    begin
        if (i_rst)
        begin
            check_value("o_mclk", 0, o_mclk);
            mclk_expect = 1'b1;
        end
        else
        begin
            check_value("o_mclk", mclk_expect, o_mclk);
            mclk_expect = ~mclk_expect;
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout after %0d clock cycles", TIMEOUT_CYCLES));
    end

    // ----------------------------------------
    // test sequence

    initial
    begin
        i_rst  = 1'b1;
        i_lr   = 1'b0;
        i_mute = 1'b0;

        // left slot loopback
        apply_reset(1'b0);
        check_reset_state();
        played_count = 0;
        wait_frames(LOOP_FRAMES);
        require_played(LOOP_FRAMES - 2);
        check_value("o_overflow", 0, o_overflow);

        // muted, the fifo fills and then drops
        i_mute <= 1'b1;
        played_count = 0;
        wait_frames(MUTE_FRAMES);
        check_value("o_overflow", 1, o_overflow);

        i_mute <= 1'b0;
        wait_frames(DRAIN_FRAMES);
        require_played(`FIFO_DEPTH);
        check_value("o_overflow", 1, o_overflow);

        // right slot loopback
        apply_reset(1'b1);
        check_reset_state();
        played_count = 0;
        wait_frames(LOOP_FRAMES);
        require_played(LOOP_FRAMES - 2);
        check_value("o_overflow", 0, o_overflow);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== mic_loopback.f ====
+incdir+.
mic_loopback_pkg.sv
mic_i2s_receiver.sv
sample_fifo.sv
i2s_audio_out.sv
level_meter.sv
mic_loopback.sv
tb_mic_loopback.sv
